//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuTopTb
FILELIST  ?= cpuTop.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard logic/*.sv tests/*.sv)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

//--- cpuTop.f
logic/isaPkg.sv
logic/cpuPkg.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/alu.sv
logic/instrMemory.sv
logic/dataMemory.sv
logic/cpuTop.sv
tests/cpuTopTb.sv

//--- logic/alu.sv
// 32-bit ALU without overflow detection; SLT is a signed compare.
module alu (
    input  cpuPkg::aluOpT           op,
    input  logic [isaPkg::xlen-1:0] a,
    input  logic [isaPkg::xlen-1:0] b,
    output logic [isaPkg::xlen-1:0] result,
    output logic                    zero
);
    import isaPkg::*;
    import cpuPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {{(xlen-1){1'b0}}, lessThan}; // 1 or 0
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // BNE takes the branch on !zero

endmodule

//--- logic/controlDecoder.sv
// Purely combinational decode; unknown opcodes and funct codes give all-inactive controls.
module controlDecoder (
    input  isaPkg::instrT instr,
    output cpuPkg::ctrlT  ctrl
);
    import isaPkg::*;
    import cpuPkg::*;

    always_comb begin
        ctrl = '0; // also the response to unknown codes
        case (instr.opcode)
            OP_RTYPE: begin
                case (instr.funct)
                    FN_ADD: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_ADD;
                    end
                    FN_SUB: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_SUB;
                    end
                    FN_AND: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_AND;
                    end
                    FN_OR: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_OR;
                    end
                    FN_SLT: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_SLT;
                    end
                    FN_JR: begin
                        ctrl.jump    = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1; // rs + offset
                ctrl.memToReg = 1'b1;
            end
            OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_BNE: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB; // zero flag compares rs and rt
            end
            OP_J:    ctrl.jump = 1'b1;
            OP_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_HALT: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- logic/cpuPkg.sv
// Core-level types: ALU operations, decoded control and the load and trace buses.
// Memory depths are in words and must be powers of two.
package cpuPkg;

    localparam int imemDepth     = 256;
    localparam int dmemDepth     = 256;
    localparam int imemAddrWidth = $clog2(imemDepth);
    localparam int dmemAddrWidth = $clog2(dmemDepth);

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_SLT = 3'd3,
        ALU_AND = 3'd4,
        ALU_OR  = 3'd7
    } aluOpT;

    typedef struct packed {
        logic  regWrite;
        logic  regDst;   // rd instead of rt
        logic  aluSrc;   // immediate as operand b
        logic  memWrite;
        logic  memToReg;
        logic  branch;   // BNE
        logic  jump;
        logic  jumpReg;  // target from rs
        logic  link;     // write PC+1 to r31
        logic  halt;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic                     en;
        logic [imemAddrWidth-1:0] addr;
        logic [isaPkg::xlen-1:0]  instr;
    } progWriteT;

    typedef struct packed {
        logic                    valid;
        logic [isaPkg::xlen-1:0] addr; // word address before truncation
        logic [isaPkg::xlen-1:0] data;
    } storeTraceT;

endpackage

//--- logic/cpuTop.sv
// Single-cycle core, PC in words; load the program through progWrite while rstN is low.
// halted follows the fetched word, so it is high during reset if word 0 is HALT.
module cpuTop (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::progWriteT  progWrite,
    output cpuPkg::storeTraceT storeTrace,
    output logic               halted
);
    import isaPkg::*;
    import cpuPkg::*;

    logic [xlen-1:0]         pc;
    logic [xlen-1:0]         pcPlus1;
    logic [xlen-1:0]         nextPc;
    logic [xlen-1:0]         instrWord;
    instrT                   instr;
    ctrlT                    ctrl;
    logic [xlen-1:0]         signExtImm;
    logic [xlen-1:0]         jumpTarget;
    logic [regAddrWidth-1:0] writeAddr;
    logic [xlen-1:0]         writeData;
    logic [xlen-1:0]         readDataA;
    logic [xlen-1:0]         readDataB;
    logic [xlen-1:0]         aluB;
    logic [xlen-1:0]         aluResult;
    logic                    aluZero;
    logic [xlen-1:0]         memReadData;
    logic                    storeValid;

    instrMemory instrMem0 (
        .clk      (clk),
        .rstN     (rstN),
        .progWrite(progWrite),
        .addr     (pc),
        .instr    (instrWord)
    );

    assign instr = instrT'(instrWord);

    controlDecoder ctrlDec0 (
        .instr(instr),
        .ctrl (ctrl)
    );

    assign signExtImm = {{(xlen-immWidth){instrWord[immWidth-1]}}, instrWord[immWidth-1:0]};
    assign jumpTarget = {{(xlen-targetWidth){1'b0}}, instrWord[targetWidth-1:0]};

    // link wins over regDst, regDst over rt
    assign writeAddr = ctrl.link   ? regAddrWidth'(31) :
                       ctrl.regDst ? instr.rd : instr.rt;
    assign writeData = ctrl.link     ? pcPlus1 :
                       ctrl.memToReg ? memReadData : aluResult;

    registerFile regFile0 (
        .clk      (clk),
        .rstN     (rstN),
        .readAddrA(instr.rs),
        .readAddrB(instr.rt),
        .writeAddr(writeAddr),
        .writeEn  (ctrl.regWrite),
        .writeData(writeData),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    assign aluB = ctrl.aluSrc ? signExtImm : readDataB;

    alu alu0 (
        .op    (ctrl.aluOp),
        .a     (readDataA),
        .b     (aluB),
        .result(aluResult),
        .zero  (aluZero)
    );

    assign storeValid = ctrl.memWrite && rstN; // no stores while the program loads

    dataMemory dataMem0 (
        .clk      (clk),
        .writeEn  (storeValid),
        .addr     (aluResult),
        .writeData(readDataB),
        .readData (memReadData)
    );

    assign storeTrace = '{valid: storeValid, addr: aluResult, data: readDataB};

    assign pcPlus1 = pc + 1'b1;

    always_comb begin
        if (ctrl.halt) begin
            nextPc = pc;
        end else if (ctrl.jump && ctrl.jumpReg) begin
            nextPc = readDataA; // JR
        end else if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (ctrl.branch && !aluZero) begin
            nextPc = pcPlus1 + signExtImm;
        end else begin
            nextPc = pcPlus1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    assign halted = ctrl.halt;

    // every running instruction must decode to at least one active control
    knownInstr: assert property (@(posedge clk) disable iff (!rstN) ctrl != '0);

    pcFrozen: assert property (@(posedge clk) disable iff (!rstN) halted |=> $stable(pc));

endmodule

//--- logic/dataMemory.sv
// Word-wide data store, not cleared by reset; the upper address bits are ignored.
module dataMemory (
    input  logic                    clk,
    input  logic                    writeEn,
    input  logic [isaPkg::xlen-1:0] addr,
    input  logic [isaPkg::xlen-1:0] writeData,
    output logic [isaPkg::xlen-1:0] readData
);
    import isaPkg::*;
    import cpuPkg::*;

    logic [xlen-1:0] mem [dmemDepth];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[addr[dmemAddrWidth-1:0]] <= writeData;
        end
    end

    assign readData = mem[addr[dmemAddrWidth-1:0]]; // read-before-write within a cycle

endmodule

//--- logic/instrMemory.sv
// Program store, loaded only while rstN is low; PC addresses wrap to the store depth.
module instrMemory (
    input  logic                    clk,
    input  logic                    rstN,
    input  cpuPkg::progWriteT       progWrite,
    input  logic [isaPkg::xlen-1:0] addr,
    output logic [isaPkg::xlen-1:0] instr
);
    import isaPkg::*;
    import cpuPkg::*;

    logic [xlen-1:0] mem [imemDepth];

    always_ff @(posedge clk) begin
        if (!rstN && progWrite.en) begin // load port is dead once the core runs
            mem[progWrite.addr] <= progWrite.instr;
        end
    end

    assign instr = mem[addr[imemAddrWidth-1:0]];

endmodule

//--- logic/isaPkg.sv
// MIPS subset encodings for a word-addressed core; only the listed opcodes and funct codes decode.
// HALT reuses the reserved opcode 63 and has no MIPS counterpart.
package isaPkg;

    localparam int xlen         = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth     = 16; // I-type immediate, low bits of the word
    localparam int targetWidth  = 26; // J-type target, low bits of the word

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f  // reserved slot
    } opcodeT;

    typedef enum logic [5:0] {
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } functT;

    // R-type layout; I-type and J-type fields are taken as slices of the low bits
    typedef struct packed {
        opcodeT                  opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0]              shamt;
        functT                   funct;
    } instrT;

endpackage

//--- logic/registerFile.sv
// 32 x 32 registers, asynchronous reads, write at the rising edge; r0 ignores writes.
module registerFile (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [isaPkg::regAddrWidth-1:0] readAddrA,
    input  logic [isaPkg::regAddrWidth-1:0] readAddrB,
    input  logic [isaPkg::regAddrWidth-1:0] writeAddr,
    input  logic                            writeEn,
    input  logic [isaPkg::xlen-1:0]         writeData,
    output logic [isaPkg::xlen-1:0]         readDataA,
    output logic [isaPkg::xlen-1:0]         readDataB
);
    import isaPkg::*;

    localparam int regCount = 1 << regAddrWidth;

    logic [xlen-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    // r0 is cleared by reset and must survive every later write
    r0StaysZero: assert property (@(posedge clk) disable iff (!rstN) regs[0] == '0);

endmodule

//--- tests/cpuTopTb.sv
// Directed tests for the single-cycle core; each program is loaded through progWrite in reset.
// Stores are sampled at the falling edge, while the core's combinational outputs are stable.
module cpuTopTb;
    timeunit 1ns;
    timeprecision 100ps;
    import isaPkg::*;
    import cpuPkg::*;

    localparam int clkHalf    = 10;
    localparam int driveSkew  = 1;  // inputs change this long after the rising edge
    localparam int resetHold  = 5;
    localparam int idleCycles = 20;
    // six programs, each under 100 cycles of load, reset, run and idle time
    localparam int maxCycles  = 2000;

    logic       clk;
    logic       rstN;
    progWriteT  progWrite;
    storeTraceT storeTrace;
    logic       halted;

    logic [xlen-1:0] prog[$];
    logic [63:0]     expected[$]; // {addr, data}
    storeTraceT      traces[$];
    int              cycles = 0;

    cpuTop dut0 (.*);

    always #clkHalf clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > maxCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", maxCycles);
            abortRun();
        end
    end

    always @(negedge clk) begin
        if (rstN && storeTrace.valid) begin
            traces.push_back(storeTrace);
        end
    end

    task automatic abortRun();
        $display("Something failed");
        $fatal(1, "run stopped at %0d ns", $time);
    endtask

    task automatic checkEqual(input logic [xlen-1:0] actual, input logic [xlen-1:0] want,
                              input string what);
        if (actual !== want) begin
            $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, actual, want);
            abortRun();
        end
    endtask

    function automatic logic [xlen-1:0] rType(functT fn, logic [4:0] rd, logic [4:0] rs,
                                              logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    // operand order follows the assembly form, e.g. ADDI rt, rs, imm
    function automatic logic [xlen-1:0] iType(opcodeT op, logic [4:0] rt, logic [4:0] rs,
                                              logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [xlen-1:0] jType(opcodeT op, logic [25:0] target);
        return {op, target};
    endfunction

    function automatic logic [xlen-1:0] signExtend(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic expectStore(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        expected.push_back({addr, data});
    endtask

    task automatic loadProgram();
        @(posedge clk);
        #driveSkew;
        rstN = 1'b0;
        traces.delete();
        foreach (prog[i]) begin
            progWrite = '{en: 1'b1, addr: imemAddrWidth'(i), instr: prog[i]};
            @(posedge clk);
            #driveSkew;
        end
        progWrite = '0;
        repeat (resetHold) @(posedge clk);
        #driveSkew;
        rstN = 1'b1;
    endtask

    // waits for HALT, checks that the core stays put, then compares the store trace
    task automatic runAndCheck(input string name);
        logic [63:0] want;
        while (halted !== 1'b1) @(negedge clk);
        repeat (idleCycles) begin
            @(negedge clk);
            checkEqual(halted, 1'b1, {name, ": halted dropped after HALT"});
        end
        @(posedge clk); // last monitor sample lands before the compare
        checkEqual(traces.size(), expected.size(), {name, ": number of stores"});
        foreach (expected[i]) begin
            want = expected[i];
            checkEqual(traces[i].addr, want[63:32], $sformatf("%s: store %0d address", name, i));
            checkEqual(traces[i].data, want[31:0], $sformatf("%s: store %0d data", name, i));
        end
        prog.delete();
        expected.delete();
    endtask

    task automatic runArithmetic();
        logic [15:0]     immA;
        logic [15:0]     immB;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        immA = 16'($urandom);
        immB = 16'($urandom);
        a = signExtend(immA);
        b = signExtend(immB);
        prog.push_back(iType(OP_ADDI, 1, 0, immA));
        prog.push_back(iType(OP_ADDI, 2, 0, immB));
        prog.push_back(rType(FN_ADD, 3, 1, 2));
        prog.push_back(iType(OP_SW, 3, 0, 0));
        prog.push_back(rType(FN_SUB, 4, 1, 2));
        prog.push_back(iType(OP_SW, 4, 0, 1));
        prog.push_back(rType(FN_AND, 5, 1, 2));
        prog.push_back(iType(OP_SW, 5, 0, 2));
        prog.push_back(rType(FN_OR, 6, 1, 2));
        prog.push_back(iType(OP_SW, 6, 0, 3));
        prog.push_back(rType(FN_SLT, 7, 1, 2));
        prog.push_back(iType(OP_SW, 7, 0, 4));
        prog.push_back(rType(FN_SLT, 8, 2, 1));
        prog.push_back(iType(OP_SW, 8, 0, 5));
        prog.push_back(jType(OP_HALT, 0));
        expectStore(0, a + b);
        expectStore(1, a - b);
        expectStore(2, a & b);
        expectStore(3, a | b);
        expectStore(4, ($signed(a) < $signed(b)) ? 1 : 0);
        expectStore(5, ($signed(b) < $signed(a)) ? 1 : 0);
        loadProgram();
        runAndCheck("arithmetic");
    endtask

    task automatic runMemory();
        logic [15:0] imm;
        imm = 16'($urandom);
        prog.push_back(iType(OP_ADDI, 1, 0, imm));
        prog.push_back(iType(OP_SW, 1, 0, 10));
        prog.push_back(iType(OP_LW, 2, 0, 10));
        prog.push_back(iType(OP_SW, 2, 0, 11));
        prog.push_back(iType(OP_ADDI, 3, 0, 20));
        prog.push_back(iType(OP_SW, 2, 3, -2)); // negative offset from a base register
        prog.push_back(iType(OP_ADDI, 0, 0, 123));
        prog.push_back(iType(OP_SW, 0, 0, 12));
        prog.push_back(iType(OP_LW, 0, 0, 10));
        prog.push_back(iType(OP_SW, 0, 0, 13));
        prog.push_back(jType(OP_HALT, 0));
        expectStore(10, signExtend(imm));
        expectStore(11, signExtend(imm));
        expectStore(18, signExtend(imm));
        expectStore(12, 0);
        expectStore(13, 0);
        loadProgram();
        runAndCheck("memory");
    endtask

    task automatic runBranch();
        int count;
        count = 3 + int'($urandom % 5);
        prog.push_back(iType(OP_ADDI, 1, 0, 16'(count)));
        prog.push_back(iType(OP_SW, 1, 0, 32)); // loop head at word 1
        prog.push_back(iType(OP_ADDI, 1, 1, -1));
        prog.push_back(iType(OP_BNE, 0, 1, -3));
        prog.push_back(iType(OP_SW, 1, 0, 33));
        prog.push_back(iType(OP_ADDI, 2, 0, 55));
        prog.push_back(iType(OP_BNE, 2, 2, 1)); // equal operands so no branch
        prog.push_back(iType(OP_SW, 2, 0, 34));
        prog.push_back(jType(OP_HALT, 0));
        for (int k = count; k >= 1; k--) begin
            expectStore(32, k);
        end
        expectStore(33, 0);
        expectStore(34, 55);
        loadProgram();
        runAndCheck("branch");
    endtask

    task automatic runJumps();
        prog.push_back(jType(OP_J, 2));
        prog.push_back(iType(OP_SW, 0, 0, 40)); // skipped by the jump
        prog.push_back(jType(OP_JAL, 6));
        prog.push_back(iType(OP_ADDI, 5, 0, 77));
        prog.push_back(iType(OP_SW, 5, 0, 43));
        prog.push_back(jType(OP_HALT, 0));
        prog.push_back(iType(OP_SW, 31, 0, 41));
        prog.push_back(rType(FN_JR, 0, 31, 0));
        expectStore(41, 3); // link of the JAL at word 2
        expectStore(43, 77);
        loadProgram();
        runAndCheck("jumps");
    endtask

    initial begin
        void'($urandom(32'h6b53));
        clk = 1'b0;
        rstN = 1'b0;
        progWrite = '0;
        repeat (3) runArithmetic();
        runMemory();
        runBranch();
        runJumps();
        $display("Everything OK");
        $finish;
    end

endmodule
